// File: flist.f
+incdir+.
vred_pkg.sv
vred_lane_if.sv
vred_csr.sv
data_validation.sv
vred_ctrl.sv
vred_lane_accum.sv
vred_top.sv
tb_clkgen.sv
tb_vred.sv

// File: run.sh
#!/bin/sh
# build and run the vred testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   -f flist.f --top-module tb_vred -o tb_vred

./obj_dir/tb_vred > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
exit 0

// File: tb_vred.sv
`include "vred_macros.svh"

module tb_vred;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 64;  // cycles per wait
   localparam int POLL_LIMIT = 40;  // status reads before giving up

   logic                                     clk_i;
   logic                                     rst_i;
   logic                                     wb_cyc_i;
   logic                                     wb_stb_i;
   logic                                     wb_we_i;
   logic [`VRED_WB_AW - 1 : 0]               wb_adr_i;
   logic [31:0]                              wb_dat_i;
   logic [3:0]                               wb_sel_i;
   logic [31:0]                              wb_dat_o;
   logic                                     wb_ack_o;
   logic                                     elem_valid_i;
   logic [`VRED_LANES * `VRED_ELEM_W - 1 : 0] elem_data_i;
   logic                                     elem_ready_o;

   logic [31:0] lfsr = 32'h7206f2b5;
   logic [15:0] elems [$];  // every element sent in the current job, stream order
   logic [31:0] rd;
   int          sweep [5] = '{0, 1, 8, 33, 63};
   int          checks = 0;
   int          errors = 0;
   int          tests = 0;
   int          err_mark = 0;

   tb_clkgen clkgen_inst (.clk_o(clk_i));

   vred_top vred_top_inst (.*);

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   // first vl elements in stream order, wrapped to the accumulator width
   function automatic logic [23:0] model_sum(input int vl);
      logic [23:0] sum;
      sum = '0;
      for (int e = 0; e < vl; e++) begin
         sum = sum + 24'(elems[e]);
      end
      return sum;
   endfunction

   task automatic check_value(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp)
      else begin
         errors++;
         $display("CHECK FAILED %s %s expected 0x%0h actual 0x%0h", test, what, exp, act);
      end
   endtask

   task automatic give_up(input string what);
      $display("timeout: %s", what);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == err_mark) begin
         $display("test %s ok", name);
      end else begin
         $display("test %s had %0d failed checks", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // classic cycle, held through the edge that sees ack
   task automatic wb_access(input logic we, input logic [`VRED_WB_AW - 1 : 0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int n;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_sel_i = 4'hF;
      n = 0;
      @(negedge clk_i);
      while (!wb_ack_o && n < WAIT_LIMIT) begin
         @(negedge clk_i);
         n++;
      end
      if (!wb_ack_o) begin
         give_up($sformatf("no wishbone ack seen for address 0x%0h", adr));
      end
      rdat = wb_dat_o;
      @(negedge clk_i);  // write commits on this edge
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wb_write(input logic [`VRED_WB_AW - 1 : 0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      wb_access(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [`VRED_WB_AW - 1 : 0] adr, output logic [31:0] dat);
      wb_access(1'b0, adr, 32'h0, dat);
   endtask

   task automatic send_beat(input logic [`VRED_LANES * `VRED_ELEM_W - 1 : 0] data);
      int n;
      elem_valid_i = 1'b1;
      elem_data_i  = data;
      n = 0;
      while (!elem_ready_o && n < WAIT_LIMIT) begin
         @(negedge clk_i);
         n++;
      end
      if (!elem_ready_o) begin
         give_up("elem_ready_o never rose for a pending beat");
      end
      @(negedge clk_i);  // taken on the rising edge in between
      elem_valid_i = 1'b0;
   endtask

   task automatic wait_done(output logic [31:0] st);
      int n;
      n  = 0;
      st = '0;
      while (!st[1] && n < POLL_LIMIT) begin
         wb_read(vred_pkg::REG_STATUS, st);
         n++;
      end
      if (!st[1]) begin
         give_up("done bit in STATUS never set");
      end
   endtask

   task automatic run_job(input string name, input int vl, input bit gaps, input int restart_at);
      logic [`VRED_LANES * `VRED_ELEM_W - 1 : 0] data;
      logic [31:0] bits;
      logic [31:0] res;
      int          nbeats;
      elems.delete();
      nbeats = vl / `VRED_LANES + 1;  // the tail beat may carry nothing
      wb_write(vred_pkg::REG_VL, 32'(vl));
      wb_write(vred_pkg::REG_CTRL, 32'h1);
      for (int b = 0; b < nbeats; b++) begin
         if (b == restart_at) begin
            wb_write(vred_pkg::REG_CTRL, 32'h1);  // engine is busy here
         end
         for (int l = 0; l < `VRED_LANES; l++) begin
            draw_bits(16, bits);
            if (bits[15:0] == 16'h0) begin
               bits[0] = 1'b1;  // masked lanes always hold something
            end
            data[l * 16 +: 16] = bits[15:0];
            elems.push_back(bits[15:0]);
         end
         if (gaps) begin
            draw_bits(2, bits);
            repeat (bits[1:0]) @(negedge clk_i);
         end
         send_beat(data);
         check_value(name, $sformatf("ready after beat %0d", b),
                     32'(b < nbeats - 1), 32'(elem_ready_o));
      end
      wait_done(res);
      check_value(name, "status", 32'h2, res);
      wb_read(vred_pkg::REG_RESULT, res);
      check_value(name, $sformatf("result vl %0d", vl), 32'(model_sum(vl)), res);
   endtask

   initial begin
      rst_i        = 1'b0;
      wb_cyc_i     = 1'b0;
      wb_stb_i     = 1'b0;
      wb_we_i      = 1'b0;
      wb_adr_i     = '0;
      wb_dat_i     = '0;
      wb_sel_i     = '0;
      elem_valid_i = 1'b0;
      elem_data_i  = '0;
      repeat (2) @(negedge clk_i);
      rst_i = 1'b1;

      check_value("reset", "ready", 32'h0, 32'(elem_ready_o));
      check_value("reset", "ack", 32'h0, 32'(wb_ack_o));
      wb_read(vred_pkg::REG_STATUS, rd);
      check_value("reset", "status", 32'h0, rd);
      wb_read(vred_pkg::REG_RESULT, rd);
      check_value("reset", "result", 32'h0, rd);
      wb_write(vred_pkg::REG_VL, 32'd37);
      wb_read(vred_pkg::REG_VL, rd);
      check_value("reset", "vl readback", 32'd37, rd);
      end_test("reset");

      run_job("tail_mask", 21, 1'b0, -1);
      end_test("tail_mask");
      run_job("short_vl", 5, 1'b0, -1);
      end_test("short_vl");
      run_job("whole_beats", 16, 1'b0, -1);
      end_test("whole_beats");
      for (int i = 0; i < 5; i++) begin
         run_job("backpressure", sweep[i], 1'b1, -1);
      end
      end_test("backpressure");
      run_job("busy_start", 40, 1'b1, 2);
      end_test("busy_start");

      $display("tests %0d, checks %0d, failed checks %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: tb_clkgen.sv
module tb_clkgen #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk_o
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

endmodule

// File: vred_top.sv
`include "vred_macros.svh"

module vred_top (
   input  logic                                     clk_i,
   input  logic                                     rst_i,

   input  logic                                     wb_cyc_i,
   input  logic                                     wb_stb_i,
   input  logic                                     wb_we_i,
   input  logic [`VRED_WB_AW - 1 : 0]               wb_adr_i,
   input  vred_pkg::wb_data_t                       wb_dat_i,
   input  logic [3:0]                               wb_sel_i,
   output vred_pkg::wb_data_t                       wb_dat_o,
   output logic                                     wb_ack_o,

   input  logic                                     elem_valid_i,
   input  logic [`VRED_LANES * `VRED_ELEM_W - 1 : 0] elem_data_i,
   output logic                                     elem_ready_o
);

   vred_pkg::vl_t  vl;
   vred_pkg::acc_t result;
   logic           start;
   logic           busy;
   logic           done;
   logic           last_beat;

   vred_lane_if lane_if ();

   vred_csr csr_inst (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .vl_o     (vl),
      .start_o  (start),
      .busy_i   (busy),
      .done_i   (done),
      .result_i (result)
   );

   data_validation #(
      .MAX_VL_PER_LANE (`VRED_MAX_VL_PER_LANE),
      .VLANE_NUM       (`VRED_LANES)
   ) valid_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .vl_i        (vl),
      .lane        (lane_if.valid_mp),
      .last_beat_o (last_beat)
   );

   vred_ctrl ctrl_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start),
      .elem_valid_i (elem_valid_i),
      .elem_data_i  (elem_data_i),
      .elem_ready_o (elem_ready_o),
      .last_beat_i  (last_beat),
      .lane         (lane_if.ctrl_mp),
      .busy_o       (busy),
      .done_o       (done)
   );

   vred_lane_accum accum_inst (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .lane     (lane_if.accum_mp),
      .result_o (result)
   );

endmodule

// File: vred_lane_accum.sv
`include "vred_macros.svh"

module vred_lane_accum (
   input  logic           clk_i,
   input  logic           rst_i,
   vred_lane_if.accum_mp  lane,
   output vred_pkg::acc_t result_o
);

   vred_pkg::acc_t acc [`VRED_LANES];
   vred_pkg::acc_t fold_add;

   // lane 1 joins the running sum in lane 0 only if it ever got data
   assign fold_add = lane.partial_valid ? acc[1] : '0;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int i = 0; i < `VRED_LANES; i++) begin
            acc[i] <= '0;
         end
      end else if (lane.load) begin
         for (int i = 0; i < `VRED_LANES; i++) begin
            acc[i] <= '0;
         end
      end else if (lane.shift_en) begin
         for (int i = 0; i < `VRED_LANES; i++) begin
            if (lane.valid[i]) begin
               acc[i] <= acc[i] + vred_pkg::acc_t'(lane.elem[i]);  // wraps
            end
         end
      end else if (lane.shift_partial) begin
         acc[0] <= acc[0] + fold_add;
         for (int i = 1; i < `VRED_LANES - 1; i++) begin
            acc[i] <= acc[i + 1];  // shift down one lane
         end
         acc[`VRED_LANES - 1] <= '0;
      end
   end

   assign result_o = acc[0];

endmodule

// File: vred_ctrl.sv
`include "vred_macros.svh"

module vred_ctrl (
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic                                     start_i,
   input  logic                                     elem_valid_i,
   input  logic [`VRED_LANES * `VRED_ELEM_W - 1 : 0] elem_data_i,
   output logic                                     elem_ready_o,
   input  logic                                     last_beat_i,
   vred_lane_if.ctrl_mp                             lane,
   output logic                                     busy_o,
   output logic                                     done_o
);

   localparam int FOLD_W = $clog2(`VRED_LANES);
   localparam logic [FOLD_W - 1 : 0] FOLD_LAST = FOLD_W'(`VRED_LANES - 2);

   vred_pkg::ctrl_state_t state;
   logic [FOLD_W - 1 : 0] fold_cnt;
   logic                  beat_xfer;

   assign elem_ready_o = (state == vred_pkg::st_stream);
   assign beat_xfer    = elem_ready_o & elem_valid_i;

   assign lane.elem          = elem_data_i;
   assign lane.load          = (state == vred_pkg::st_load);
   assign lane.shift_en      = beat_xfer;
   assign lane.shift_partial = (state == vred_pkg::st_fold);

   assign busy_o = (state != vred_pkg::st_idle);
   assign done_o = (state == vred_pkg::st_done);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state    <= vred_pkg::st_idle;
         fold_cnt <= '0;
      end else begin
         case (state)
            vred_pkg::st_idle: begin
               if (start_i) begin
                  state <= vred_pkg::st_load;
               end
            end
            vred_pkg::st_load: begin
               state <= vred_pkg::st_stream;
            end
            vred_pkg::st_stream: begin
               if (beat_xfer && last_beat_i) begin
                  state    <= vred_pkg::st_fold;
                  fold_cnt <= '0;
               end
            end
            vred_pkg::st_fold: begin
               fold_cnt <= fold_cnt + 1'b1;
               if (fold_cnt == FOLD_LAST) begin  // lanes - 1 steps
                  state <= vred_pkg::st_done;
               end
            end
            vred_pkg::st_done: begin
               state <= vred_pkg::st_idle;
            end
            default: begin
               state <= vred_pkg::st_idle;
            end
         endcase
      end
   end

endmodule

// File: data_validation.sv
`include "vred_macros.svh"

module data_validation #(
   parameter int MAX_VL_PER_LANE = `VRED_MAX_VL_PER_LANE,
   parameter int VLANE_NUM       = `VRED_LANES
) (
   input  logic          clk_i,
   input  logic          rst_i,
   input  vred_pkg::vl_t vl_i,
   vred_lane_if.valid_mp lane,
   output logic          last_beat_o
);

   localparam int LANE_W = $clog2(VLANE_NUM);
   localparam int CNT_W  = $clog2(MAX_VL_PER_LANE);

   logic [LANE_W - 1 : 0]    mod_in;
   logic [CNT_W - 1 : 0]     div_in;
   logic [CNT_W - 1 : 0]     div_q;
   logic [CNT_W - 1 : 0]     base_counter;  // index of the current beat
   logic [VLANE_NUM - 1 : 0] last_valid;
   logic [VLANE_NUM - 1 : 0] last_valid_comb;
   logic [VLANE_NUM - 2 : 0] partial_results_reg;  // bit 0 is lane 1

   // vl split into whole beats and the tail count
   assign mod_in = vl_i[LANE_W - 1 : 0];
   assign div_in = vl_i[LANE_W +: CNT_W];

   always_comb begin
      last_valid_comb = '0;
      for (int i = 0; i < VLANE_NUM; i++) begin
         last_valid_comb[i] = (i < int'(mod_in));
      end
   end

   assign last_beat_o = (base_counter == div_q);

   // tail beat gets the low mod lanes only, and it may have none
   assign lane.valid = (last_beat_o ? last_valid : {VLANE_NUM{1'b1}})
                       & {VLANE_NUM{lane.shift_en}};

   assign lane.partial_valid = partial_results_reg[0];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         div_q               <= '0;
         base_counter        <= '0;
         last_valid          <= '0;
         partial_results_reg <= '0;
      end else begin
         if (lane.load) begin
            div_q        <= div_in;
            base_counter <= '0;
            last_valid   <= last_valid_comb;
            if (div_in == '0) begin
               // single beat, only lanes below mod ever see data
               partial_results_reg <= last_valid_comb[VLANE_NUM - 1 : 1];
            end else begin
               partial_results_reg <= '1;
            end
         end else if (lane.shift_en) begin
            if (!last_beat_o) begin
               base_counter <= base_counter + 1'b1;
            end
         end else if (lane.shift_partial) begin
            partial_results_reg <= partial_results_reg >> 1;  // follows the lane shift
         end
      end
   end

endmodule

// File: vred_csr.sv
`include "vred_macros.svh"

module vred_csr (
   input  logic                      clk_i,
   input  logic                      rst_i,

   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  logic [`VRED_WB_AW - 1 : 0] wb_adr_i,
   input  vred_pkg::wb_data_t        wb_dat_i,
   input  logic [3:0]                wb_sel_i,
   output vred_pkg::wb_data_t        wb_dat_o,
   output logic                      wb_ack_o,

   output vred_pkg::vl_t             vl_o,
   output logic                      start_o,
   input  logic                      busy_i,
   input  logic                      done_i,
   input  vred_pkg::acc_t            result_i
);

   vred_pkg::vl_t  vl_q;
   vred_pkg::acc_t result_q;
   logic           done_q;
   logic           ack_q;
   logic           wb_req;
   logic           wb_wr;
   logic           ctrl_start;

   assign wb_req = wb_cyc_i & wb_stb_i;
   // writes commit in the ack cycle, the host still holds the bus
   assign wb_wr  = wb_req & ack_q & wb_we_i;

   assign ctrl_start = wb_wr & (wb_adr_i == vred_pkg::REG_CTRL) & wb_sel_i[0] & wb_dat_i[0];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb_req & ~ack_q;  // single cycle ack
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         vl_q     <= '0;
         start_o  <= 1'b0;
         done_q   <= 1'b0;
         result_q <= '0;
      end else begin
         start_o <= ctrl_start & ~busy_i;  // start while busy is dropped

         if (wb_wr && wb_adr_i == vred_pkg::REG_VL && wb_sel_i[0]) begin
            vl_q <= wb_dat_i[$bits(vred_pkg::vl_t) - 1 : 0];
         end

         if (start_o) begin
            done_q <= 1'b0;
         end else if (done_i) begin
            done_q <= 1'b1;
         end

         if (done_i) begin
            result_q <= result_i;  // stays readable until the next job ends
         end
      end
   end

   // read data lands together with the ack
   always_ff @(posedge clk_i) begin
      if (wb_req && !ack_q) begin
         case (wb_adr_i)
            vred_pkg::REG_VL:     wb_dat_o <= vred_pkg::wb_data_t'(vl_q);
            vred_pkg::REG_STATUS: wb_dat_o <= {30'b0, done_q, busy_i};
            vred_pkg::REG_RESULT: wb_dat_o <= vred_pkg::wb_data_t'(result_q);
            default:              wb_dat_o <= '0;  // ctrl reads as zero
         endcase
      end
   end

   assign wb_ack_o = ack_q;
   assign vl_o     = vl_q;

endmodule

// File: vred_lane_if.sv
`include "vred_macros.svh"

interface vred_lane_if;

   vred_pkg::elem_t [`VRED_LANES - 1 : 0] elem;  // lane 0 in the low bits
   vred_pkg::lane_mask_t                  valid;
   logic                                  shift_en;       // beat accepted
   logic                                  shift_partial;  // one fold step
   logic                                  partial_valid;
   logic                                  load;

   modport ctrl_mp (
      output elem, shift_en, shift_partial, load
   );

   modport valid_mp (
      input  shift_en, shift_partial, load,
      output valid, partial_valid
   );

   modport accum_mp (
      input elem, valid, shift_en, shift_partial, partial_valid, load
   );

endinterface

// File: vred_pkg.sv
`include "vred_macros.svh"

package vred_pkg;

   // vector length, 0 to lanes * max per lane - 1
   typedef logic [$clog2(`VRED_LANES * `VRED_MAX_VL_PER_LANE) - 1 : 0] vl_t;

   typedef logic [`VRED_ELEM_W - 1 : 0] elem_t;
   typedef logic [`VRED_LANES - 1 : 0]  lane_mask_t;
   typedef logic [`VRED_ACC_W - 1 : 0]  acc_t;
   typedef logic [31:0]                 wb_data_t;

   // register map, byte offsets
   localparam logic [`VRED_WB_AW - 1 : 0] REG_VL     = 'h0;
   localparam logic [`VRED_WB_AW - 1 : 0] REG_CTRL   = 'h4;
   localparam logic [`VRED_WB_AW - 1 : 0] REG_STATUS = 'h8;
   localparam logic [`VRED_WB_AW - 1 : 0] REG_RESULT = 'hC;

   typedef enum logic [2:0] {
      st_idle,
      st_load,    // clear sums, latch vl
      st_stream,  // accept beats
      st_fold,    // serial lane fold
      st_done
   } ctrl_state_t;

endpackage

// File: vred_macros.svh
`ifndef VRED_MACROS_SVH
`define VRED_MACROS_SVH

// lanes per element beat
`define VRED_LANES 8

// beats worth of elements per lane, sets the largest vl
`define VRED_MAX_VL_PER_LANE 8

// element width in bits
`define VRED_ELEM_W 16

// lane sums and the result wrap at this width
`define VRED_ACC_W 24

// wishbone byte address width
`define VRED_WB_AW 4

`endif
